// ==== md_pkg.sv ====
package md_pkg;

	// datapath width
	localparam int word_w = 32;

	// multiplier: operands sampled on the accept edge, product
	// readable mul_lat cycles later
	localparam int mul_lat = 5;

	// divider: start cycle to done pulse
	localparam int div_lat = 33;

	// counter widths and terminal counts
	localparam int mul_cnt_w = $clog2(mul_lat);
	localparam int div_cnt_w = $clog2(word_w);

	localparam logic [mul_cnt_w-1:0] mul_last = mul_cnt_w'(mul_lat - 1);
	localparam logic [div_cnt_w-1:0] div_last = div_cnt_w'(word_w - 1); // last shift step

	typedef logic [word_w-1:0] word_t;

	// op codes as issued by the decode stage
	typedef enum logic [3:0] {
		op_multu = 4'd0,
		op_mult  = 4'd1,
		op_divu  = 4'd2,
		op_div   = 4'd3,
		op_maddu = 4'd4,
		op_madd  = 4'd5,
		op_msub  = 4'd6,
		op_msubu = 4'd7,
		op_mul   = 4'd8
	} md_op_t;

	// HI/LO pair, hi in the upper half
	// for divides hi is the remainder and lo the quotient
	typedef struct packed {
		word_t hi;
		word_t lo;
	} hilo_t;

	// one multiply/divide request
	typedef struct packed {
		md_op_t op;
		word_t  a; // rs
		word_t  b; // rt
	} md_req_t;

endpackage

// ==== mul_pipe.sv ====
module mul_pipe (
	input  logic          clk,
	input  md_pkg::word_t a,
	input  md_pkg::word_t b,
	input  logic          mul_signed,
	output md_pkg::hilo_t prod
);

	// operands widened by one bit, top bit is the sign or zero
	logic [md_pkg::word_w:0] ax;
	logic [md_pkg::word_w:0] bx;

	// 33-bit values sign extended to the full 66-bit product width
	logic [2*md_pkg::word_w+1:0] ax_w;
	logic [2*md_pkg::word_w+1:0] bx_w;
	logic [2*md_pkg::word_w+1:0] full;

	// stage 0 holds the raw product, the rest only delay it
	md_pkg::hilo_t stage [md_pkg::mul_lat];

	assign ax = {mul_signed & a[md_pkg::word_w-1], a};
	assign bx = {mul_signed & b[md_pkg::word_w-1], b};

	assign ax_w = {{(md_pkg::word_w+1){ax[md_pkg::word_w]}}, ax};
	assign bx_w = {{(md_pkg::word_w+1){bx[md_pkg::word_w]}}, bx};

	// low 64 bits are exact for both signed and unsigned operands
	assign full = ax_w * bx_w;

	always_ff @(posedge clk) begin
		stage[0] <= md_pkg::hilo_t'(full[2*md_pkg::word_w-1:0]);
		for (int i = 1; i < md_pkg::mul_lat; i++) begin
			stage[i] <= stage[i-1];
		end
	end

	// free running, the sequencer counts cycles to find its product
	assign prod = stage[md_pkg::mul_lat-1];

endmodule

// ==== div_iter.sv ====
module div_iter (
	input  logic          clk,
	input  logic          rst,
	input  logic          start,
	input  logic          div_signed,
	input  md_pkg::word_t a,
	input  md_pkg::word_t b,
	output logic          done,
	output md_pkg::hilo_t res
);

	// operand signs and magnitudes at start
	logic          a_neg;
	logic          b_neg;
	md_pkg::word_t a_mag;
	md_pkg::word_t b_mag;

	// control
	logic                          run;
	logic [md_pkg::div_cnt_w-1:0] step;

	// datapath
	md_pkg::word_t rem;  // partial remainder
	md_pkg::word_t quo;  // dividend shifting out, quotient shifting in
	md_pkg::word_t dvs;  // divisor magnitude
	logic          q_neg;
	logic          r_neg;

	logic [md_pkg::word_w:0] shifted;
	logic [md_pkg::word_w:0] diff;
	logic                    fits;

	assign a_neg = div_signed & a[md_pkg::word_w-1];
	assign b_neg = div_signed & b[md_pkg::word_w-1];
	assign a_mag = a_neg ? -a : a; // 0x80000000 maps onto itself, still right unsigned
	assign b_mag = b_neg ? -b : b;

	// one restoring step: shift in next dividend bit, try to subtract
	assign shifted = {rem, quo[md_pkg::word_w-1]};
	assign diff    = shifted - {1'b0, dvs};
	assign fits    = shifted >= {1'b0, dvs};

	always_ff @(posedge clk) begin
		if (!rst) begin
			run  <= 1'b0;
			step <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0; // single cycle pulse
			if (start) begin
				run  <= 1'b1;
				step <= '0;
			end else if (run) begin
				step <= step + 1'b1;
				if (step == md_pkg::div_last) begin
					run  <= 1'b0;
					done <= 1'b1; // next cycle is the fix-up
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			rem   <= '0;
			quo   <= a_mag;
			dvs   <= b_mag;
			q_neg <= a_neg ^ b_neg;
			r_neg <= a_neg; // remainder follows the dividend
		end else if (run) begin
			if (fits) begin
				rem <= diff[md_pkg::word_w-1:0];
			end else begin
				rem <= shifted[md_pkg::word_w-1:0];
			end
			quo <= {quo[md_pkg::word_w-2:0], fits};
		end
	end

	// sign fix-up, read by the sequencer while done is high
	always_comb begin
		res.lo = q_neg ? -quo : quo;
		res.hi = r_neg ? -rem : rem;
	end

endmodule

// ==== md_seq.sv ====
module md_seq (
	input  logic            clk,
	input  logic            rst,
	input  md_pkg::md_req_t req,
	input  logic            start,
	input  logic            flush,
	input  logic            hilo_wr,
	input  logic            wr_hi,
	input  md_pkg::word_t   wr_data,
	input  logic            rd_hi,
	output logic            busy,
	output md_pkg::word_t   rd_data,
	output logic            mul_signed,
	input  md_pkg::hilo_t   prod,
	output logic            div_start,
	output logic            div_signed,
	input  md_pkg::hilo_t   div_res,
	input  logic            div_done
);

	// what happens to the product on the way into HI/LO
	typedef enum logic [1:0] {
		mode_plain,
		mode_add,
		mode_sub
	} mul_mode_t;

	typedef struct packed {
		logic      valid;
		logic      is_div;
		logic      sgn;
		mul_mode_t mode;
	} op_dec_t;

	typedef enum logic [1:0] {
		st_idle,
		st_mul,
		st_div
	} state_t;

	op_dec_t                      dec;
	state_t                       state;
	logic [md_pkg::mul_cnt_w-1:0] cnt;     // multiply wait
	mul_mode_t                    mode_q;
	md_pkg::hilo_t                base;    // HI/LO at accept, for madd/msub
	md_pkg::hilo_t                hilo;
	md_pkg::hilo_t                mul_res;
	logic                         accept;
	logic                         mul_end;

	always_comb begin
		dec.valid  = 1'b1;
		dec.is_div = 1'b0;
		dec.sgn    = 1'b0;
		dec.mode   = mode_plain;
		case (req.op)
			md_pkg::op_multu: dec.sgn = 1'b0;
			md_pkg::op_mult,
			md_pkg::op_mul: dec.sgn = 1'b1; // mul only lands in HI/LO here
			md_pkg::op_divu: dec.is_div = 1'b1;
			md_pkg::op_div: begin
				dec.is_div = 1'b1;
				dec.sgn    = 1'b1;
			end
			md_pkg::op_maddu: dec.mode = mode_add;
			md_pkg::op_madd: begin
				dec.sgn  = 1'b1;
				dec.mode = mode_add;
			end
			md_pkg::op_msub: begin
				dec.sgn  = 1'b1;
				dec.mode = mode_sub;
			end
			md_pkg::op_msubu: dec.mode = mode_sub;
			default: dec.valid = 1'b0; // unknown codes never start
		endcase
	end

	assign busy   = (state != st_idle);
	assign accept = start & ~flush & ~busy & dec.valid;

	// operands go straight from req to both units
	assign mul_signed = dec.sgn;
	assign div_signed = dec.sgn;
	assign div_start  = accept & dec.is_div;

	assign mul_end = (state == st_mul) && (cnt == md_pkg::mul_last);

	always_comb begin
		case (mode_q)
			mode_add: mul_res = md_pkg::hilo_t'(base + prod); // wraps mod 2^64
			mode_sub: mul_res = md_pkg::hilo_t'(base - prod);
			default:  mul_res = prod;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			state  <= st_idle;
			cnt    <= '0;
			mode_q <= mode_plain;
		end else begin
			case (state)
				st_idle: begin
					if (accept) begin
						state  <= dec.is_div ? st_div : st_mul;
						cnt    <= '0;
						mode_q <= dec.mode;
					end
				end
				st_mul: begin
					cnt <= cnt + 1'b1;
					if (mul_end) begin
						state <= st_idle;
					end
				end
				st_div: begin
					if (div_done) begin
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			base <= hilo;
		end
	end

	// results win, direct writes only while idle and not starting
	always_ff @(posedge clk) begin
		if (!rst) begin
			hilo <= '0;
		end else if (mul_end) begin
			hilo <= mul_res;
		end else if (state == st_div && div_done) begin
			hilo <= div_res;
		end else if (hilo_wr && !busy && !accept) begin
			if (wr_hi) begin
				hilo.hi <= wr_data; // mthi
			end else begin
				hilo.lo <= wr_data; // mtlo
			end
		end
	end

	assign rd_data = rd_hi ? hilo.hi : hilo.lo;

endmodule

// ==== hilo_md_unit.sv ====
module hilo_md_unit (
	input  logic            clk,
	input  logic            rst,
	input  md_pkg::md_req_t req,
	input  logic            start,
	input  logic            flush,
	input  logic            hilo_wr,
	input  logic            wr_hi,
	input  md_pkg::word_t   wr_data,
	input  logic            rd_hi,
	output logic            busy,
	output md_pkg::word_t   rd_data
);

	logic          mul_signed;
	md_pkg::hilo_t prod;
	logic          div_start;
	logic          div_signed;
	logic          div_done;
	md_pkg::hilo_t div_res;

	md_seq i_md_seq (
		.clk        (clk),
		.rst        (rst),
		.req        (req),
		.start      (start),
		.flush      (flush),
		.hilo_wr    (hilo_wr),
		.wr_hi      (wr_hi),
		.wr_data    (wr_data),
		.rd_hi      (rd_hi),
		.busy       (busy),
		.rd_data    (rd_data),
		.mul_signed (mul_signed),
		.prod       (prod),
		.div_start  (div_start),
		.div_signed (div_signed),
		.div_res    (div_res),
		.div_done   (div_done)
	);

	// both units see the raw request operands
	mul_pipe i_mul_pipe (
		.clk        (clk),
		.a          (req.a),
		.b          (req.b),
		.mul_signed (mul_signed),
		.prod       (prod)
	);

	div_iter i_div_iter (
		.clk        (clk),
		.rst        (rst),
		.start      (div_start),
		.div_signed (div_signed),
		.a          (req.a),
		.b          (req.b),
		.done       (div_done),
		.res        (div_res)
	);

endmodule

// ==== tb_hilo_md_unit.sv ====
module tb_hilo_md_unit;

	localparam int n_mix   = 400;                        // accepted ops in the random mix
	localparam int n_dir   = 120;                        // directed ops, rounded up
	localparam int max_cyc = (n_mix + n_dir) * 40 + 500;

	logic            clk;
	logic            rst;
	md_pkg::md_req_t req;
	logic            start;
	logic            flush;
	logic            hilo_wr;
	logic            wr_hi;
	md_pkg::word_t   wr_data;
	logic            rd_hi;
	logic            busy;
	md_pkg::word_t   rd_data;

	md_pkg::hilo_t model;     // architectural HI/LO
	md_pkg::hilo_t pending;   // result of the op in flight
	int            busy_left; // busy cycles still to come
	int            n_acc;     // accepted requests so far
	int            cyc = 0;

	hilo_md_unit i_hilo_md_unit (
		.clk     (clk),
		.rst     (rst),
		.req     (req),
		.start   (start),
		.flush   (flush),
		.hilo_wr (hilo_wr),
		.wr_hi   (wr_hi),
		.wr_data (wr_data),
		.rd_hi   (rd_hi),
		.busy    (busy),
		.rd_data (rd_data)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	// watchdog
	always @(posedge clk) begin
		cyc = cyc + 1;
		if (cyc > max_cyc) begin
			fail_run($sformatf("timeout, run still going after %0d cycles", cyc));
		end
	end

	// mostly random, with the corner values mixed in
	function automatic md_pkg::word_t pick_operand();
		case ($urandom % 8)
			0: return 32'h8000_0000;
			1: return 32'hffff_ffff;
			2: return 32'h7fff_ffff;
			3: return 32'($urandom % 16);
			default: return $urandom;
		endcase
	endfunction

	function automatic md_pkg::word_t pick_divisor();
		md_pkg::word_t d;
		d = pick_operand();
		if (d == '0) begin
			d = 32'd1; // divide by zero is undefined
		end
		return d;
	endfunction

	function automatic int op_latency(input md_pkg::md_op_t op);
		if (op == md_pkg::op_div || op == md_pkg::op_divu) begin
			return md_pkg::div_lat;
		end
		return md_pkg::mul_lat;
	endfunction

	function automatic md_pkg::hilo_t expected_result(input md_pkg::md_op_t op,
			input md_pkg::word_t a, input md_pkg::word_t b, input md_pkg::hilo_t base);
		longint      sa;
		longint      sb;
		logic [63:0] ua;
		logic [63:0] ub;
		logic [63:0] sp; // signed product
		logic [63:0] up; // unsigned product
		logic [63:0] r;
		sa = longint'($signed(a));
		sb = longint'($signed(b));
		ua = {32'h0, a};
		ub = {32'h0, b};
		sp = sa * sb;
		up = ua * ub;
		case (op)
			md_pkg::op_multu: r = up;
			md_pkg::op_maddu: r = base + up;
			md_pkg::op_madd:  r = base + sp;
			md_pkg::op_msub:  r = base - sp;
			md_pkg::op_msubu: r = base - up;
			// remainder in hi and quotient in lo
			// 64-bit math keeps min by -1 in range
			md_pkg::op_div:   r = {32'(sa % sb), 32'(sa / sb)};
			md_pkg::op_divu:  r = {32'(ua % ub), 32'(ua / ub)};
			default:          r = sp; // mult and mul
		endcase
		return md_pkg::hilo_t'(r);
	endfunction

	task automatic set_idle();
		req.op  = md_pkg::op_multu;
		req.a   = '0;
		req.b   = '0;
		start   = 1'b0;
		flush   = 1'b0;
		hilo_wr = 1'b0;
		wr_hi   = 1'b0;
		wr_data = '0;
		rd_hi   = 1'($urandom);
	endtask

	task automatic check_outputs();
		logic          exp_busy;
		md_pkg::word_t exp_rd;
		exp_busy = (busy_left > 0);
		exp_rd   = rd_hi ? model.hi : model.lo;
		assert (busy === exp_busy) else begin
			fail_run($sformatf("error busy: got %h, expected %h", busy, exp_busy));
		end
		assert (rd_data === exp_rd) else begin
			fail_run($sformatf("error rd_data (rd_hi %h): got %h, expected %h",
				rd_hi, rd_data, exp_rd));
		end
	endtask

	// model the coming rising edge, then check at the falling edge
	task automatic tick();
		if (busy_left > 0) begin
			busy_left--;
			if (busy_left == 0) begin
				model = pending;
			end
		end else if (start && !flush) begin
			pending   = expected_result(req.op, req.a, req.b, model);
			busy_left = op_latency(req.op);
			n_acc++;
		end else if (hilo_wr) begin
			if (wr_hi) begin
				model.hi = wr_data;
			end else begin
				model.lo = wr_data;
			end
		end
		@(negedge clk);
		check_outputs();
	endtask

	task automatic read_both();
		set_idle();
		rd_hi = 1'b1;
		tick();
		set_idle();
		rd_hi = 1'b0;
		tick();
	endtask

	task automatic write_hilo(input logic hi, input md_pkg::word_t data);
		set_idle();
		hilo_wr = 1'b1;
		wr_hi   = hi;
		wr_data = data;
		tick();
	endtask

	task automatic issue_op(input md_pkg::md_op_t op, input md_pkg::word_t a,
			input md_pkg::word_t b);
		int n;
		set_idle();
		req.op = op;
		req.a  = a;
		req.b  = b;
		start  = 1'b1;
		tick();
		n = 0;
		while (busy === 1'b1 && n <= md_pkg::div_lat) begin
			n++;
			set_idle();
			tick();
		end
	endtask

	task automatic ignored_inputs();
		set_idle();
		req.op = md_pkg::op_mult;
		req.a  = pick_operand();
		req.b  = pick_operand();
		start  = 1'b1;
		flush  = 1'b1; // cancels the start
		tick();
		read_both();
		// start and write in one cycle, the write is dropped
		set_idle();
		req.op  = md_pkg::op_multu;
		req.a   = pick_operand();
		req.b   = pick_operand();
		start   = 1'b1;
		hilo_wr = 1'b1;
		wr_hi   = 1'($urandom);
		wr_data = $urandom;
		tick();
		for (int i = 0; i < md_pkg::mul_lat; i++) begin
			set_idle();
			req.op  = md_pkg::op_divu;
			req.a   = pick_operand();
			req.b   = pick_divisor();
			start   = 1'b1;
			hilo_wr = 1'b1;
			wr_hi   = 1'($urandom);
			wr_data = $urandom;
			tick();
		end
		read_both();
	endtask

	task automatic random_mix();
		int target;
		target = n_acc + n_mix;
		while (n_acc < target) begin
			set_idle();
			req.op = md_pkg::md_op_t'(4'($urandom % 9));
			req.a  = pick_operand();
			if (req.op == md_pkg::op_div || req.op == md_pkg::op_divu) begin
				req.b = pick_divisor();
			end else begin
				req.b = pick_operand();
			end
			start   = ($urandom % 3) == 0;
			flush   = ($urandom % 8) == 0;
			hilo_wr = ($urandom % 3) == 0;
			wr_hi   = 1'($urandom);
			wr_data = pick_operand();
			tick();
		end
	endtask

	initial begin
		void'($urandom(32'h6bd7));
		model     = '0;
		pending   = '0;
		busy_left = 0;
		n_acc     = 0;
		set_idle();
		rst = 1'b0;
		repeat (3) @(negedge clk);
		rst = 1'b1;
		read_both(); // HI/LO cleared by reset

		for (int i = 0; i < 10; i++) begin
			issue_op(md_pkg::op_mult, pick_operand(), pick_operand());
			read_both();
			issue_op(md_pkg::op_multu, pick_operand(), pick_operand());
			read_both();
			issue_op(md_pkg::op_mul, pick_operand(), pick_operand());
			read_both();
		end

		// accumulate on a freshly loaded base
		for (int i = 0; i < 40; i++) begin
			write_hilo(1'b1, $urandom);
			write_hilo(1'b0, $urandom);
			issue_op(md_pkg::md_op_t'(4'(4 + i % 4)), pick_operand(), pick_operand());
			read_both();
		end

		issue_op(md_pkg::op_div, -32'sd7, 32'sd2);
		read_both();
		issue_op(md_pkg::op_div, 32'sd7, -32'sd2);
		read_both();
		issue_op(md_pkg::op_div, -32'sd7, -32'sd2);
		read_both();
		issue_op(md_pkg::op_div, 32'h8000_0000, 32'hffff_ffff);
		read_both();
		for (int i = 0; i < 15; i++) begin
			issue_op(md_pkg::op_div, pick_operand(), pick_divisor());
			read_both();
			issue_op(md_pkg::op_divu, pick_operand(), pick_divisor());
			read_both();
		end

		repeat (5) ignored_inputs();
		random_mix();
		read_both();

		$display(">>> PASS");
		$finish;
	end

endmodule

// ==== tb.f ====
md_pkg.sv
mul_pipe.sv
div_iter.sv
md_seq.sv
hilo_md_unit.sv
tb_hilo_md_unit.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module tb_hilo_md_unit -f tb.f -o tb_sim \
	&& ./obj_dir/tb_sim \
	|| exit 1
